// ==== vlog.f ====
+incdir+.
cpuPkg.sv
addressUnit.sv
executeUnit.sv
controlUnit.sv
cpuSystem.sv
cpuSystemTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpuSystemTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== cpuTestPrograms.svh ====
localparam int testCount = 5;

// Eight instruction words per row, stored low byte first from address 0
localparam wordT programTable [testCount][8] = '{
    // MOVL R2 5A, STA R2 40
    '{16'h665A, 16'h8240, 16'h0004, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    // MOVL R1 12, MOVSH R1 34, STA R1 50
    '{16'h6512, 16'h6934, 16'h8150, 16'h0006, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    // MOVL R0 3, loop DEC R0 and BNE, STA R0 60
    '{16'h6403, 16'h2800, 16'h0402, 16'h8060, 16'h0008, 16'h0000, 16'h0000, 16'h0000},
    // Single DEC with BEQ not taken
    '{16'h6403, 16'h2800, 16'h0802, 16'h8060, 16'h0008, 16'h0000, 16'h0000, 16'h0000},
    // BRA skips the second MOVL R3
    '{16'h6777, 16'h0006, 16'h6799, 16'h8370, 16'h0008, 16'h0000, 16'h0000, 16'h0000}
};

// Expected store address and value, and short instructions run before STA
localparam addressT storeAddressTable [testCount] = '{8'h40, 8'h50, 8'h60, 8'h60, 8'h70};
localparam wordT    storeValueTable [testCount]   = '{
    16'h005A, 16'h1234, 16'h0000, 16'h0002, 16'h0077
};
localparam int      shortCountTable [testCount]   = '{1, 2, 7, 3, 2};

// ==== cpuSystemTb.sv ====
`timescale 1ns/1ps

module cpuSystemTb;
    import cpuPkg::*;

    `include "cpuTestPrograms.svh"

    localparam int timeoutCycles = 200;

    logic        Clock;
    logic        Reset;
    byteT        MemReadData;
    timingT      T;
    addressT     MemAddress;
    logic        MemSelect;
    logic        MemWrite;
    byteT        MemWriteData;

    byteT        memory [256];
    addressT     writeAddressQ [$];
    byteT        writeDataQ [$];
    int          writeCycleQ [$];
    logic        storePending;
    addressT     storeAddress;
    byteT        storeData;
    int          releaseCycles;                      // Cycles since reset release
    int          readCount;                          // Fetch reads before the first store
    int          currentTest;
    int          errorCount;
    int          checkCount;
    logic [31:0] seed;

    cpuSystem uut (
        .Clock        (Clock),
        .Reset        (Reset),
        .MemReadData  (MemReadData),
        .T            (T),
        .MemAddress   (MemAddress),
        .MemSelect    (MemSelect),
        .MemWrite     (MemWrite),
        .MemWriteData (MemWriteData)
    );

    assign MemReadData = memory[MemAddress];         // Combinational read

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    // ==================================================
    // Helpers
    // ==================================================
    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s (test %0d): got 0x%0h, expected 0x%0h",
                     name, currentTest, actual, expected);
        end
    endtask

    // Drive on the rising edge and sample at the falling edge
    task automatic runCycle(input logic resetValue);
        @(posedge Clock);
        Reset <= resetValue;
        if (storePending) begin
            memory[storeAddress] <= storeData;       // Write lands on this edge
            storePending = 1'b0;
        end
        @(negedge Clock);
        compareValue("T one-hot", 32'($onehot(T)), 32'd1);
        if (Reset) begin
            compareValue("T", 32'(T), 32'(stateT0));
            compareValue("MemWrite", 32'(MemWrite), 32'd0);
            releaseCycles = 0;
        end else begin
            if (MemSelect && !MemWrite && writeAddressQ.size() == 0) begin
                readCount++;
            end
            if (MemSelect && MemWrite) begin
                storePending = 1'b1;
                storeAddress = MemAddress;
                storeData    = MemWriteData;
                writeAddressQ.push_back(MemAddress);
                writeDataQ.push_back(MemWriteData);
                writeCycleQ.push_back(releaseCycles);
            end
            releaseCycles++;
        end
    endtask

    task automatic loadProgram(input int testIndex);
        for (int i = 0; i < 256; i++) begin
            memory[i] <= 8'h00;
        end
        for (int k = 0; k < 8; k++) begin
            memory[2*k]     <= programTable[testIndex][k][7:0];
            memory[2*k + 1] <= programTable[testIndex][k][15:8];
        end
    endtask

    task automatic runTest(input int testIndex);
        int      waitCycles;
        int      firstCycle;
        addressT lowAddress;
        addressT highAddress;
        wordT    expected;
        currentTest = testIndex;
        loadProgram(testIndex);
        writeAddressQ.delete();
        writeDataQ.delete();
        writeCycleQ.delete();
        storePending = 1'b0;
        readCount    = 0;
        for (int i = 0; i < 4; i++) begin
            runCycle(1'b1);                          // Reset held 4 cycles
        end
        waitCycles = 0;
        while (writeAddressQ.size() < 2 && waitCycles < timeoutCycles) begin
            runCycle(1'b0);
            waitCycles++;
        end
        if (writeAddressQ.size() < 2) begin
            errorCount++;
            $display("Test %0d timed out after %0d cycles waiting for two store writes",
                     testIndex, waitCycles);
        end else begin
            runCycle(1'b0);                          // High byte reaches memory
            lowAddress  = storeAddressTable[testIndex];
            highAddress = lowAddress + 8'd1;
            expected    = storeValueTable[testIndex];
            firstCycle  = 4 * shortCountTable[testIndex] + 4;
            compareValue("MemAddress low", 32'(writeAddressQ[0]), 32'(lowAddress));
            compareValue("MemAddress high", 32'(writeAddressQ[1]), 32'(highAddress));
            compareValue("MemWriteData low", 32'(writeDataQ[0]), 32'(expected[7:0]));
            compareValue("MemWriteData high", 32'(writeDataQ[1]), 32'(expected[15:8]));
            compareValue("MemWrite cycle low", 32'(writeCycleQ[0]), 32'(firstCycle));
            compareValue("MemWrite cycle high", 32'(writeCycleQ[1]), 32'(firstCycle + 1));
            compareValue("MemSelect reads", 32'(readCount),
                         32'(2 * (shortCountTable[testIndex] + 1)));
            compareValue("memory low", 32'(memory[lowAddress]), 32'(expected[7:0]));
            compareValue("memory high", 32'(memory[highAddress]), 32'(expected[15:8]));
        end
    endtask

    // ==================================================
    // Test loop
    // ==================================================
    initial begin
        Reset <= 1'b1;
        seed          = 32'h66d1_91aa;
        errorCount    = 0;
        checkCount    = 0;
        currentTest   = 0;
        releaseCycles = 0;
        readCount     = 0;
        storePending  = 1'b0;
        for (int t = 0; t < testCount; t++) begin
            runTest(t);
        end
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== cpuSystem.sv ====
`timescale 1ns/1ps

module cpuSystem (
    input  logic           Clock,
    input  logic           Reset,
    input  cpuPkg::byteT   MemReadData,
    output cpuPkg::timingT T,
    output cpuPkg::addressT MemAddress,
    output logic           MemSelect,
    output logic           MemWrite,
    output cpuPkg::byteT   MemWriteData
);
    import cpuPkg::*;

    // ==================================================
    // Control strobes between the units
    // ==================================================
    logic        pcIncrement;
    logic        pcLoad;
    logic        arLoad;
    logic        arIncrement;
    logic        addrFromAr;
    logic        regWrite;
    regFunctionT regFunction;
    regIndexT    regSelect;
    byteT        immediate;                          // Address or immediate field
    logic        storeHigh;
    logic        zeroFlag;

    controlUnit control (
        .Clock       (Clock),
        .Reset       (Reset),
        .MemReadData (MemReadData),
        .ZeroFlag    (zeroFlag),
        .T           (T),
        .PcIncrement (pcIncrement),
        .PcLoad      (pcLoad),
        .ArLoad      (arLoad),
        .ArIncrement (arIncrement),
        .AddrFromAr  (addrFromAr),
        .MemSelect   (MemSelect),
        .MemWrite    (MemWrite),
        .RegWrite    (regWrite),
        .RegFunction (regFunction),
        .RegSelect   (regSelect),
        .Immediate   (immediate),
        .StoreHigh   (storeHigh)
    );

    addressUnit address (
        .Clock       (Clock),
        .Reset       (Reset),
        .PcIncrement (pcIncrement),
        .PcLoad      (pcLoad),
        .ArLoad      (arLoad),
        .ArIncrement (arIncrement),
        .AddrFromAr  (addrFromAr),
        .Immediate   (immediate),
        .MemAddress  (MemAddress)
    );

    executeUnit execute (
        .Clock        (Clock),
        .Reset        (Reset),
        .RegWrite     (regWrite),
        .RegFunction  (regFunction),
        .RegSelect    (regSelect),
        .Immediate    (immediate),
        .StoreHigh    (storeHigh),
        .MemWriteData (MemWriteData),
        .ZeroFlag     (zeroFlag)
    );

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
    input  logic                Clock,
    input  logic                Reset,
    input  cpuPkg::byteT        MemReadData,
    input  logic                ZeroFlag,
    output cpuPkg::timingT      T,
    output logic                PcIncrement,
    output logic                PcLoad,
    output logic                ArLoad,
    output logic                ArIncrement,
    output logic                AddrFromAr,
    output logic                MemSelect,
    output logic                MemWrite,
    output logic                RegWrite,
    output cpuPkg::regFunctionT RegFunction,
    output cpuPkg::regIndexT    RegSelect,
    output cpuPkg::byteT        Immediate,
    output logic                StoreHigh
);
    import cpuPkg::*;

    wordT   instructionReg;
    opcodeT opcode;
    logic   lastState;                               // Final state of this instruction

    // ==================================================
    // Timing ring
    // ==================================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            T <= stateT0;
        end else if (lastState) begin
            T <= stateT0;                            // Restart for the next fetch
        end else begin
            T <= {T[10:0], T[11]};                   // Rotate one state
        end
    end

    // Instruction register takes the low byte first
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            instructionReg <= '0;
        end else if (T == stateT0) begin
            instructionReg[7:0] <= MemReadData;
        end else if (T == stateT1) begin
            instructionReg[15:8] <= MemReadData;
        end
    end

    // ==================================================
    // Decode
    // ==================================================
    assign opcode    = instructionReg[15:10];
    assign RegSelect = instructionReg[9:8];
    assign Immediate = instructionReg[7:0];          // Address or immediate

    // ==================================================
    // Strobe generation
    // ==================================================
    always_comb begin
        PcIncrement = 1'b0;
        PcLoad      = 1'b0;
        ArLoad      = 1'b0;
        ArIncrement = 1'b0;
        AddrFromAr  = 1'b0;
        MemSelect   = 1'b0;
        MemWrite    = 1'b0;
        RegWrite    = 1'b0;
        RegFunction = regHold;
        StoreHigh   = 1'b0;
        lastState   = 1'b0;

        case (T)
            stateT0, stateT1: begin
                MemSelect   = 1'b1;                  // Read instruction byte at PC
                PcIncrement = 1'b1;
            end
            stateT3: begin
                lastState = 1'b1;                    // Most instructions end here
                case (opcode)
                    opBra:   PcLoad = 1'b1;
                    opBne:   PcLoad = ~ZeroFlag;
                    opBeq:   PcLoad = ZeroFlag;
                    opMovl: begin
                        RegWrite    = 1'b1;
                        RegFunction = regLoad;
                    end
                    opMovsh: begin
                        RegWrite    = 1'b1;
                        RegFunction = regShiftLoad;
                    end
                    opDec: begin
                        RegWrite    = 1'b1;
                        RegFunction = regDecrement;
                    end
                    opSta: begin
                        ArLoad    = 1'b1;            // AR takes the address field
                        lastState = 1'b0;
                    end
                    default: lastState = 1'b1;       // Unknown opcode is a no-op
                endcase
            end
            stateT4: begin
                if (opcode == opSta) begin
                    AddrFromAr  = 1'b1;
                    MemSelect   = 1'b1;
                    MemWrite    = 1'b1;              // Low byte
                    ArIncrement = 1'b1;
                end
            end
            stateT5: begin
                if (opcode == opSta) begin
                    AddrFromAr = 1'b1;
                    MemSelect  = 1'b1;
                    MemWrite   = 1'b1;
                    StoreHigh  = 1'b1;               // High byte at address+1
                end
                lastState = 1'b1;
            end
            stateT6, stateT7, stateT8, stateT9, stateT10, stateT11: begin
                lastState = 1'b1;                    // Unused states fall back to fetch
            end
            default: lastState = 1'b0;               // T2 decodes with no strobes
        endcase
    end

endmodule

// ==== executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit (
    input  logic                Clock,
    input  logic                Reset,
    input  logic                RegWrite,
    input  cpuPkg::regFunctionT RegFunction,
    input  cpuPkg::regIndexT    RegSelect,
    input  cpuPkg::byteT        Immediate,
    input  logic                StoreHigh,
    output cpuPkg::byteT        MemWriteData,
    output logic                ZeroFlag
);
    import cpuPkg::*;

    wordT registers [4];                             // R0 to R3
    wordT selectedValue;
    wordT nextValue;

    assign selectedValue = registers[RegSelect];

    // ==================================================
    // Register function
    // ==================================================
    always_comb begin
        case (RegFunction)
            regLoad:      nextValue = {8'h00, Immediate};
            regShiftLoad: nextValue = {selectedValue[7:0], Immediate};
            regDecrement: nextValue = selectedValue - 16'd1;
            default:      nextValue = selectedValue; // Hold
        endcase
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < 4; i++) begin
                registers[i] <= '0;
            end
            ZeroFlag <= 1'b0;
        end else if (RegWrite) begin
            registers[RegSelect] <= nextValue;
            if (RegFunction == regDecrement) begin
                ZeroFlag <= (nextValue == '0);       // Only DEC touches Z
            end
        end
    end

    // ==================================================
    // Store byte select
    // ==================================================
    assign MemWriteData = StoreHigh ? selectedValue[15:8] : selectedValue[7:0];

endmodule

// ==== addressUnit.sv ====
`timescale 1ns/1ps

module addressUnit (
    input  logic            Clock,
    input  logic            Reset,
    input  logic            PcIncrement,
    input  logic            PcLoad,
    input  logic            ArLoad,
    input  logic            ArIncrement,
    input  logic            AddrFromAr,
    input  cpuPkg::byteT    Immediate,
    output cpuPkg::addressT MemAddress
);
    import cpuPkg::*;

    addressT programCounter;
    addressT addressRegister;

    // ==================================================
    // Program counter
    // ==================================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            programCounter <= '0;
        end else if (PcLoad) begin
            programCounter <= Immediate;             // Branch target
        end else if (PcIncrement) begin
            programCounter <= programCounter + 8'd1;
        end
    end

    // ==================================================
    // Address register
    // ==================================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            addressRegister <= '0;
        end else if (ArLoad) begin
            addressRegister <= Immediate;            // Store address from IR
        end else if (ArIncrement) begin
            addressRegister <= addressRegister + 8'd1;
        end
    end

    // Fetch uses the PC, stores use AR
    assign MemAddress = AddrFromAr ? addressRegister : programCounter;

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

    // ==================================================
    // Widths and basic types
    // ==================================================
    localparam int dataWidth = 16;                   // Register and instruction width

    typedef logic [7:0]           byteT;             // One memory byte
    typedef logic [7:0]           addressT;          // 256-byte address space
    typedef logic [dataWidth-1:0] wordT;
    typedef logic [5:0]           opcodeT;
    typedef logic [1:0]           regIndexT;         // R0 to R3
    typedef logic [11:0]          timingT;           // One-hot timing ring

    // ==================================================
    // One-hot timing states
    // ==================================================
    localparam timingT stateT0  = 12'b0000_0000_0001;
    localparam timingT stateT1  = 12'b0000_0000_0010;
    localparam timingT stateT2  = 12'b0000_0000_0100;
    localparam timingT stateT3  = 12'b0000_0000_1000;
    localparam timingT stateT4  = 12'b0000_0001_0000;
    localparam timingT stateT5  = 12'b0000_0010_0000;
    localparam timingT stateT6  = 12'b0000_0100_0000;
    localparam timingT stateT7  = 12'b0000_1000_0000;
    localparam timingT stateT8  = 12'b0001_0000_0000;
    localparam timingT stateT9  = 12'b0010_0000_0000;
    localparam timingT stateT10 = 12'b0100_0000_0000;
    localparam timingT stateT11 = 12'b1000_0000_0000;

    // ==================================================
    // Opcodes in instruction bits 15:10
    // ==================================================
    localparam opcodeT opBra   = 6'h00;
    localparam opcodeT opBne   = 6'h01;
    localparam opcodeT opBeq   = 6'h02;
    localparam opcodeT opDec   = 6'h0A;
    localparam opcodeT opMovl  = 6'h19;
    localparam opcodeT opMovsh = 6'h1A;
    localparam opcodeT opSta   = 6'h20;

    // Register file operation
    typedef enum logic [1:0] {
        regHold,
        regLoad,                                     // Zero-extended immediate
        regShiftLoad,                                // Shift left 8 with immediate in low byte
        regDecrement
    } regFunctionT;

endpackage
